//--- filelist.f
+incdir+hdl
hdl/scaler_pkg.sv
hdl/line_capture.sv
hdl/line_store.sv
hdl/scale_stepper.sv
hdl/pixel_emitter.sv
hdl/video_scaler_top.sv
sim/video_scaler_assertions.sv
sim/video_scaler_tb.sv

//--- hdl/line_capture.sv
`timescale 1ns/1ps
`include "scaler_params.svh"

module line_capture (
	input  logic                      i_ClkB,
	input  logic                      i_rst_n,
	input  scaler_pkg::scale_cfg_t    i_cfg,
	input  logic                      i_in_valid,
	input  scaler_pkg::pixel_t        i_in_pixel,
	input  logic [`SC_COORD_BITS-1:0] i_need_line,
	input  logic                      i_frame_done,
	output logic                      o_in_ready,
	output logic                      o_wr_en,
	output logic [`SC_SLOT_BITS-1:0]  o_wr_slot,
	output logic [`SC_COORD_BITS-1:0] o_wr_col,
	output scaler_pkg::pixel_t        o_wr_pixel,
	output logic [`SC_COORD_BITS-1:0] o_lines_done
);

	logic [`SC_COORD_BITS-1:0] col_q;
	logic [`SC_COORD_BITS-1:0] col_nx;
	logic [`SC_COORD_BITS-1:0] done_q;
	logic [`SC_COORD_BITS-1:0] done_nx;
	logic [`SC_COORD_BITS-1:0] held_lines;
	logic                      wait_q;
	logic                      wait_nx;
	logic                      pend_q;
	logic                      pend_nx;
	logic                      ready_q;
	logic                      ready_nx;
	logic                      wr;

	assign wr = i_in_valid && ready_q;

	// the line being written is always line number done_q
	assign o_in_ready = ready_q;
	assign o_wr_en = wr;
	assign o_wr_slot = done_q[`SC_SLOT_BITS-1:0];
	assign o_wr_col = col_q;
	assign o_wr_pixel = i_in_pixel;
	assign o_lines_done = done_q;

	always_comb begin
		col_nx = col_q;
		done_nx = done_q;
		wait_nx = wait_q;
		// emitter may finish before the unused bottom lines arrive
		pend_nx = pend_q || i_frame_done;

		if (wr) begin
			if (col_q == i_cfg.in_width - 1'b1) begin
				col_nx = '0;
				done_nx = done_q + 1'b1;
				if (done_q == i_cfg.in_height - 1'b1) begin
					wait_nx = 1'b1;
				end
			end else begin
				col_nx = col_q + 1'b1;
			end
		end

		// both sides finished, start over
		if (wait_nx && pend_nx) begin
			col_nx = '0;
			done_nx = '0;
			wait_nx = 1'b0;
			pend_nx = 1'b0;
		end

		// slots still owed to the emitter, none if it waits on a later row
		held_lines = (done_nx > i_need_line) ? done_nx - i_need_line : '0;

		// once the emitter is done with the frame no slot is owed
		ready_nx = !wait_nx && (pend_nx || (held_lines < `SC_LINE_COUNT));
	end

	always_ff @(posedge i_ClkB) begin
		if (!i_rst_n) begin
			col_q <= '0;
			done_q <= '0;
			wait_q <= 1'b0;
			pend_q <= 1'b0;
			ready_q <= 1'b0;
		end else begin
			col_q <= col_nx;
			done_q <= done_nx;
			wait_q <= wait_nx;
			pend_q <= pend_nx;
			ready_q <= ready_nx;
		end
	end

endmodule

//--- hdl/line_store.sv
`timescale 1ns/1ps
`include "scaler_params.svh"

module line_store (
	input  logic                      i_ClkB,
	input  logic                      i_wr_en,
	input  logic [`SC_SLOT_BITS-1:0]  i_wr_slot,
	input  logic [`SC_COORD_BITS-1:0] i_wr_col,
	input  scaler_pkg::pixel_t        i_wr_pixel,
	input  logic [`SC_SLOT_BITS-1:0]  i_rd_slot,
	input  logic [`SC_COORD_BITS-1:0] i_rd_col,
	output scaler_pkg::pixel_t        o_rd_pixel
);

	import scaler_pkg::*;

	localparam int DEPTH = `SC_LINE_COUNT * `SC_MAX_WIDTH;

	pixel_t mem [DEPTH];

	logic [`SC_SLOT_BITS+`SC_COL_BITS-1:0] wr_addr;
	logic [`SC_SLOT_BITS+`SC_COL_BITS-1:0] rd_addr;

	// slot selects a 1024 pixel region
	assign wr_addr = {i_wr_slot, i_wr_col[`SC_COL_BITS-1:0]};
	assign rd_addr = {i_rd_slot, i_rd_col[`SC_COL_BITS-1:0]};

	always_ff @(posedge i_ClkB) begin
		if (i_wr_en) begin
			mem[wr_addr] <= i_wr_pixel;
		end
	end

	// registered read, data one cycle after the address
	always_ff @(posedge i_ClkB) begin
		o_rd_pixel <= mem[rd_addr];
	end

endmodule

//--- hdl/pixel_emitter.sv
`timescale 1ns/1ps
`include "scaler_params.svh"

module pixel_emitter (
	input  logic                      i_ClkB,
	input  logic                      i_rst_n,
	input  logic                      i_coord_valid,
	input  scaler_pkg::src_coord_t    i_coord,
	input  logic [`SC_COORD_BITS-1:0] i_lines_done,
	input  scaler_pkg::pixel_t        i_rd_pixel,
	input  logic                      i_out_ready,
	output logic                      o_coord_ready,
	output logic [`SC_SLOT_BITS-1:0]  o_rd_slot,
	output logic [`SC_COORD_BITS-1:0] o_rd_col,
	output logic [`SC_COORD_BITS-1:0] o_need_line,
	output logic                      o_frame_done,
	output logic                      o_out_valid,
	output scaler_pkg::out_beat_t     o_out_beat
);

	logic                      adv;
	logic                      take;
	logic                      out_xfer;
	logic                      s1_valid;
	logic                      s1_sof;
	logic                      s1_eol;
	logic [`SC_COORD_BITS-1:0] s1_row;
	logic [`SC_SLOT_BITS-1:0]  rd_slot_q;
	logic [`SC_COORD_BITS-1:0] rd_col_q;
	logic                      out_last_q;
	logic                      hold_q;

	// whole pipe moves together when the output register frees up
	assign adv = !o_out_valid || i_out_ready;
	assign o_coord_ready = adv && !hold_q && (i_coord.src_y < i_lines_done);
	assign take = i_coord_valid && o_coord_ready;
	assign out_xfer = o_out_valid && i_out_ready;

	// hold the address while stalled so the store keeps returning the same pixel
	assign o_rd_slot = take ? i_coord.src_y[`SC_SLOT_BITS-1:0] : rd_slot_q;
	assign o_rd_col = take ? i_coord.src_x : rd_col_q;

	always_comb begin
		if (s1_valid) begin
			o_need_line = s1_row;
		end else if (i_coord_valid) begin
			o_need_line = i_coord.src_y;
		end else begin
			o_need_line = '0;
		end
	end

	always_ff @(posedge i_ClkB) begin
		if (!i_rst_n) begin
			s1_valid <= 1'b0;
			o_out_valid <= 1'b0;
			out_last_q <= 1'b0;
			o_frame_done <= 1'b0;
			hold_q <= 1'b0;
		end else begin
			if (adv) begin
				s1_valid <= take;
				o_out_valid <= s1_valid;
				// the stepper drops valid only after the final coordinate of a frame
				out_last_q <= s1_valid && s1_eol && !i_coord_valid;
			end
			o_frame_done <= out_xfer && out_last_q;
			// keep off the next frame until capture has cleared its line count
			if (out_xfer && out_last_q) begin
				hold_q <= 1'b1;
			end else if (i_lines_done == '0) begin
				hold_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_ClkB) begin
		if (take) begin
			rd_slot_q <= i_coord.src_y[`SC_SLOT_BITS-1:0];
			rd_col_q <= i_coord.src_x;
		end
		if (adv) begin
			s1_sof <= i_coord.sof;
			s1_eol <= i_coord.eol;
			s1_row <= i_coord.src_y;
			o_out_beat.pix <= i_rd_pixel;
			o_out_beat.sof <= s1_sof;
			o_out_beat.eol <= s1_eol;
		end
	end

endmodule

//--- hdl/scale_stepper.sv
`timescale 1ns/1ps
`include "scaler_params.svh"

module scale_stepper (
	input  logic                   i_ClkB,
	input  logic                   i_rst_n,
	input  scaler_pkg::scale_cfg_t i_cfg,
	input  logic                   i_frame_done,
	input  logic                   i_coord_ready,
	output logic                   o_coord_valid,
	output scaler_pkg::src_coord_t o_coord
);

	import scaler_pkg::*;

	typedef enum logic [1:0] {S_LOAD, S_DIV, S_RUN, S_WAIT} state_t;

	state_t                    state_q;
	scale_cfg_t                cfg_q;
	logic [`SC_STEP_BITS-1:0]  div_num;
	logic [`SC_COORD_BITS-1:0] div_rem;
	logic [4:0]                div_cnt;
	logic                      div_axis;
	logic [`SC_STEP_BITS-1:0]  step_x;
	logic [`SC_STEP_BITS-1:0]  step_y;
	logic [`SC_STEP_BITS-1:0]  acc_x;
	logic [`SC_STEP_BITS-1:0]  acc_y;
	logic [`SC_COORD_BITS-1:0] col_q;
	logic [`SC_COORD_BITS-1:0] row_q;
	logic [`SC_COORD_BITS:0]   trial;
	logic [`SC_COORD_BITS:0]   divisor;
	logic [`SC_COORD_BITS:0]   diff;
	logic                      ge;
	logic                      div_last;
	logic                      take;
	logic                      col_last;
	logic                      row_last;
	logic                      first_open;

	// restoring divide, quotient bits shift in behind the dividend
	assign trial = {div_rem, div_num[`SC_STEP_BITS-1]};
	assign divisor = {1'b0, div_axis ? cfg_q.out_height : cfg_q.out_width};
	assign ge = trial >= divisor;
	assign diff = trial - divisor;
	assign div_last = div_cnt == 5'(`SC_STEP_BITS - 1);

	assign take = o_coord_valid && i_coord_ready;
	assign col_last = col_q == cfg_q.out_width - 1'b1;
	assign row_last = row_q == cfg_q.out_height - 1'b1;
	// config changed while nothing of the frame has gone out
	assign first_open = (col_q == '0) && (row_q == '0) && !take && (i_cfg != cfg_q);

	always_comb begin
		o_coord.src_x = acc_x[`SC_FRAC_BITS +: `SC_COORD_BITS];
		o_coord.src_y = acc_y[`SC_FRAC_BITS +: `SC_COORD_BITS];
		o_coord.sof = (col_q == '0) && (row_q == '0);
		o_coord.eol = col_last;
	end

	always_ff @(posedge i_ClkB) begin
		if (!i_rst_n) begin
			state_q <= S_LOAD;
			div_cnt <= '0;
			div_axis <= 1'b0;
			col_q <= '0;
			row_q <= '0;
			acc_x <= '0;
			acc_y <= '0;
			o_coord_valid <= 1'b0;
		end else begin
			case (state_q)
				S_LOAD: begin
					div_cnt <= '0;
					div_axis <= 1'b0;
					col_q <= '0;
					row_q <= '0;
					state_q <= S_DIV;
				end
				S_DIV: begin
					div_cnt <= div_cnt + 1'b1;
					if (i_cfg != cfg_q) begin
						state_q <= S_LOAD;
					end else if (div_last) begin
						div_cnt <= '0;
						div_axis <= 1'b1;
						// y step done, first coordinate goes out
						if (div_axis) begin
							acc_x <= '0;
							acc_y <= '0;
							o_coord_valid <= 1'b1;
							state_q <= S_RUN;
						end
					end
				end
				S_RUN: begin
					if (first_open) begin
						o_coord_valid <= 1'b0;
						state_q <= S_LOAD;
					end else if (take) begin
						if (col_last) begin
							col_q <= '0;
							acc_x <= '0;
							if (row_last) begin
								o_coord_valid <= 1'b0;
								state_q <= S_WAIT;
							end else begin
								row_q <= row_q + 1'b1;
								acc_y <= acc_y + step_y;
							end
						end else begin
							col_q <= col_q + 1'b1;
							acc_x <= acc_x + step_x;
						end
					end
				end
				S_WAIT: begin
					if (i_frame_done) begin
						state_q <= S_LOAD;
					end
				end
				default: begin
					state_q <= S_LOAD;
				end
			endcase
		end
	end

	// divider datapath
	always_ff @(posedge i_ClkB) begin
		if (state_q == S_LOAD) begin
			cfg_q <= i_cfg;
			div_num <= {1'b0, i_cfg.in_width, {`SC_FRAC_BITS{1'b0}}};
			div_rem <= '0;
		end else if (state_q == S_DIV) begin
			div_num <= {div_num[`SC_STEP_BITS-2:0], ge};
			div_rem <= ge ? diff[`SC_COORD_BITS-1:0] : trial[`SC_COORD_BITS-1:0];
			if (div_last && !div_axis) begin
				step_x <= {div_num[`SC_STEP_BITS-2:0], ge};
				div_num <= {1'b0, cfg_q.in_height, {`SC_FRAC_BITS{1'b0}}};
				div_rem <= '0;
			end
			if (div_last && div_axis) begin
				step_y <= {div_num[`SC_STEP_BITS-2:0], ge};
			end
		end
	end

endmodule

//--- hdl/scaler_params.svh
`ifndef SCALER_PARAMS_SVH
`define SCALER_PARAMS_SVH

// bits per colour component
`define SC_COMPONENT_DEPTH 8

// pixel and line counters, configured frame sizes
`define SC_COORD_BITS 11

// fixed-point fraction of steps and accumulators
`define SC_FRAC_BITS 12

// pixels held by one line slot
`define SC_MAX_WIDTH 1024

// line slots in the ring, power of two
`define SC_LINE_COUNT 4

// slot index is the low bits of the line number
`define SC_SLOT_BITS 2

// column address inside one slot
`define SC_COL_BITS 10

// step and accumulator width, integer part plus fraction plus headroom
`define SC_STEP_BITS (`SC_COORD_BITS + `SC_FRAC_BITS + 1)

`endif

//--- hdl/scaler_pkg.sv
`include "scaler_params.svh"

package scaler_pkg;

	// one RGB pixel, red in the top bits
	typedef struct packed {
		logic [`SC_COMPONENT_DEPTH-1:0] red;
		logic [`SC_COMPONENT_DEPTH-1:0] green;
		logic [`SC_COMPONENT_DEPTH-1:0] blue;
	} pixel_t;

	// output stream payload
	typedef struct packed {
		pixel_t pix;
		logic   sof;
		logic   eol;
	} out_beat_t;

	// frame sizes, input and output
	typedef struct packed {
		logic [`SC_COORD_BITS-1:0] in_width;
		logic [`SC_COORD_BITS-1:0] in_height;
		logic [`SC_COORD_BITS-1:0] out_width;
		logic [`SC_COORD_BITS-1:0] out_height;
	} scale_cfg_t;

	// source position for one output pixel, markers travel with it
	typedef struct packed {
		logic [`SC_COORD_BITS-1:0] src_x;
		logic [`SC_COORD_BITS-1:0] src_y;
		logic                      sof;
		logic                      eol;
	} src_coord_t;

endpackage

//--- hdl/video_scaler_top.sv
`timescale 1ns/1ps
`include "scaler_params.svh"

module video_scaler_top (
	input  logic                   i_ClkB,
	input  logic                   i_rst_n,
	input  scaler_pkg::scale_cfg_t i_cfg,
	input  logic                   i_in_valid,
	input  scaler_pkg::pixel_t     i_in_pixel,
	output logic                   o_in_ready,
	output logic                   o_out_valid,
	output scaler_pkg::out_beat_t  o_out_beat,
	input  logic                   i_out_ready
);

	import scaler_pkg::*;

	// capture to store
	logic                      wr_en;
	logic [`SC_SLOT_BITS-1:0]  wr_slot;
	logic [`SC_COORD_BITS-1:0] wr_col;
	pixel_t                    wr_pixel;

	// line handshake between capture and emitter
	logic [`SC_COORD_BITS-1:0] lines_done;
	logic [`SC_COORD_BITS-1:0] need_line;
	logic                      frame_done;

	// coordinate stream
	logic                      coord_valid;
	logic                      coord_ready;
	src_coord_t                coord;

	// emitter read port
	logic [`SC_SLOT_BITS-1:0]  rd_slot;
	logic [`SC_COORD_BITS-1:0] rd_col;
	pixel_t                    rd_pixel;

	line_capture line_capture_inst (
		.i_ClkB       (i_ClkB),
		.i_rst_n      (i_rst_n),
		.i_cfg        (i_cfg),
		.i_in_valid   (i_in_valid),
		.i_in_pixel   (i_in_pixel),
		.i_need_line  (need_line),
		.i_frame_done (frame_done),
		.o_in_ready   (o_in_ready),
		.o_wr_en      (wr_en),
		.o_wr_slot    (wr_slot),
		.o_wr_col     (wr_col),
		.o_wr_pixel   (wr_pixel),
		.o_lines_done (lines_done)
	);

	line_store line_store_inst (
		.i_ClkB     (i_ClkB),
		.i_wr_en    (wr_en),
		.i_wr_slot  (wr_slot),
		.i_wr_col   (wr_col),
		.i_wr_pixel (wr_pixel),
		.i_rd_slot  (rd_slot),
		.i_rd_col   (rd_col),
		.o_rd_pixel (rd_pixel)
	);

	scale_stepper scale_stepper_inst (
		.i_ClkB        (i_ClkB),
		.i_rst_n       (i_rst_n),
		.i_cfg         (i_cfg),
		.i_frame_done  (frame_done),
		.i_coord_ready (coord_ready),
		.o_coord_valid (coord_valid),
		.o_coord       (coord)
	);

	pixel_emitter pixel_emitter_inst (
		.i_ClkB        (i_ClkB),
		.i_rst_n       (i_rst_n),
		.i_coord_valid (coord_valid),
		.i_coord       (coord),
		.i_lines_done  (lines_done),
		.i_rd_pixel    (rd_pixel),
		.i_out_ready   (i_out_ready),
		.o_coord_ready (coord_ready),
		.o_rd_slot     (rd_slot),
		.o_rd_col      (rd_col),
		.o_need_line   (need_line),
		.o_frame_done  (frame_done),
		.o_out_valid   (o_out_valid),
		.o_out_beat    (o_out_beat)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# build the scaler testbench with Verilator, run it, decide from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module video_scaler_tb \
	-f filelist.f -Mdir obj_dir -o video_scaler_sim > build.log 2>&1 \
	&& ./obj_dir/video_scaler_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -qF '*** TEST PASSED ***' sim.log 2>/dev/null && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}

//--- sim/video_scaler_assertions.sv
`timescale 1ns/1ps
`include "scaler_params.svh"

module emitter_assertions (
	input logic                      i_ClkB,
	input logic                      i_rst_n,
	input logic                      i_out_valid,
	input scaler_pkg::out_beat_t     i_out_beat,
	input logic                      i_out_ready,
	input logic                      i_coord_valid,
	input logic                      i_coord_ready,
	input scaler_pkg::src_coord_t    i_coord,
	input logic [`SC_COORD_BITS-1:0] i_lines_done,
	input logic                      i_frame_done
);

	// stalled beat keeps valid and payload
	beat_held: assert property (@(posedge i_ClkB) disable iff (!i_rst_n)
		(i_out_valid && !i_out_ready) |=> (i_out_valid && $stable(i_out_beat)))
		else $error("output beat changed or dropped while stalled");

	// accepted row is captured and its slot not yet reused by capture
	row_complete: assert property (@(posedge i_ClkB) disable iff (!i_rst_n)
		(i_coord_valid && i_coord_ready) |->
			((i_coord.src_y < i_lines_done)
			&& (i_lines_done - i_coord.src_y <= `SC_LINE_COUNT)))
		else $error("coordinate accepted for a row not captured or already overwritten");

	frame_done_pulse: assert property (@(posedge i_ClkB) disable iff (!i_rst_n)
		i_frame_done |=> !i_frame_done)
		else $error("frame done held for more than one cycle");

endmodule

bind pixel_emitter emitter_assertions emitter_assertions_inst (
	.i_ClkB        (i_ClkB),
	.i_rst_n       (i_rst_n),
	.i_out_valid   (o_out_valid),
	.i_out_beat    (o_out_beat),
	.i_out_ready   (i_out_ready),
	.i_coord_valid (i_coord_valid),
	.i_coord_ready (o_coord_ready),
	.i_coord       (i_coord),
	.i_lines_done  (i_lines_done),
	.i_frame_done  (o_frame_done)
);

//--- sim/video_scaler_tb.sv
`timescale 1ns/1ps
`include "scaler_params.svh"

module video_scaler_tb;

	import scaler_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int CYCLES_PER_PIXEL = 40;

	logic        i_ClkB;
	logic        i_rst_n;
	scale_cfg_t  i_cfg;
	logic        i_in_valid;
	pixel_t      i_in_pixel;
	logic        o_in_ready;
	logic        o_out_valid;
	out_beat_t   o_out_beat;
	logic        i_out_ready;

	logic [31:0] lfsr_state = 32'h1b50_b081;
	pixel_t      src_frame [0:255];

	video_scaler_top video_scaler_top_inst (
		.i_ClkB      (i_ClkB),
		.i_rst_n     (i_rst_n),
		.i_cfg       (i_cfg),
		.i_in_valid  (i_in_valid),
		.i_in_pixel  (i_in_pixel),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_beat  (o_out_beat),
		.i_out_ready (i_out_ready)
	);

	initial begin
		i_ClkB = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) i_ClkB = ~i_ClkB;
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] lfsr_bits(input int count);
		logic [31:0] value;
		int          k;
		value = '0;
		for (k = 0; k < count; k++) begin
			value = {value[30:0], lfsr_step()};
		end
		return value;
	endfunction

	function automatic int frame_budget(input int iw, input int ih, input int ow, input int oh);
		return CYCLES_PER_PIXEL * (iw * ih + ow * oh);
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
			$display("*** TEST FAILED ***");
			$fatal(1, "mismatch in %s", what);
		end
	endtask

	// valid stays up until the pixel is taken
	task automatic send_pixels(input int count, input bit gaps);
		int idx;
		bit fire;
		bit pend;
		bit took;
		idx = 0;
		pend = 1'b0;
		@(posedge i_ClkB);
		while (idx < count) begin
			fire = pend || !gaps || (lfsr_bits(2) != 0);
			i_in_valid <= fire;
			i_in_pixel <= src_frame[idx];
			@(negedge i_ClkB);
			took = fire && o_in_ready;
			@(posedge i_ClkB);
			pend = fire && !took;
			if (took) begin
				idx++;
			end
		end
		i_in_valid <= 1'b0;
	endtask

	// expected beat from the step rule, source pixel picked by truncated accumulators
	task automatic collect_beats(input int iw, input int ih, input int ow, input int oh,
		input bit stalls);
		int        cnt;
		int        step_x;
		int        step_y;
		int        sx;
		int        sy;
		bit        rdy;
		bit        got;
		out_beat_t expected;
		cnt = 0;
		step_x = (iw << `SC_FRAC_BITS) / ow;
		step_y = (ih << `SC_FRAC_BITS) / oh;
		@(posedge i_ClkB);
		while (cnt < ow * oh) begin
			rdy = !stalls || (lfsr_bits(2) != 0);
			i_out_ready <= rdy;
			@(negedge i_ClkB);
			got = o_out_valid && rdy;
			if (got) begin
				sx = ((cnt % ow) * step_x) >> `SC_FRAC_BITS;
				sy = ((cnt / ow) * step_y) >> `SC_FRAC_BITS;
				expected.pix = src_frame[sy * iw + sx];
				expected.sof = (cnt == 0);
				expected.eol = ((cnt % ow) == ow - 1);
				check_value($sformatf("beat %0d of %0dx%0d output", cnt, ow, oh),
					{6'd0, o_out_beat}, {6'd0, expected});
			end
			@(posedge i_ClkB);
			if (got) begin
				cnt++;
			end
		end
		i_out_ready <= 1'b1;
	endtask

	task automatic run_frame(input int iw, input int ih, input int ow, input int oh,
		input bit gaps, input bit stalls);
		int          i;
		logic [31:0] rnd;
		scale_cfg_t  cfg;
		for (i = 0; i < iw * ih; i++) begin
			rnd = lfsr_bits(24);
			src_frame[i] = rnd[23:0];
		end
		cfg.in_width = iw[`SC_COORD_BITS-1:0];
		cfg.in_height = ih[`SC_COORD_BITS-1:0];
		cfg.out_width = ow[`SC_COORD_BITS-1:0];
		cfg.out_height = oh[`SC_COORD_BITS-1:0];
		@(posedge i_ClkB);
		i_cfg <= cfg;
		fork
			send_pixels(iw * ih, gaps);
			collect_beats(iw, ih, ow, oh, stalls);
		join
	endtask

	task automatic test_identity();
		run_frame(8, 4, 8, 4, 1'b0, 1'b0);
	endtask

	// each source pixel becomes a 2x2 block
	task automatic test_upscale();
		run_frame(4, 3, 8, 6, 1'b0, 1'b0);
	endtask

	// rows 1, 3 and 5 are never read, so slots must free up without them
	task automatic test_downscale();
		run_frame(8, 6, 4, 3, 1'b0, 1'b0);
	endtask

	task automatic test_fractional_ratio();
		run_frame(6, 5, 9, 7, 1'b1, 1'b1);
	endtask

	task automatic test_back_to_back();
		run_frame(8, 4, 4, 4, 1'b0, 1'b0);
		run_frame(5, 3, 10, 6, 1'b0, 1'b0);
	endtask

	initial begin
		int limit;
		limit = 2000 + frame_budget(8, 4, 8, 4) + frame_budget(4, 3, 8, 6)
			+ frame_budget(8, 6, 4, 3) + frame_budget(6, 5, 9, 7)
			+ frame_budget(8, 4, 4, 4) + frame_budget(5, 3, 10, 6);
		repeat (limit) @(posedge i_ClkB);
		$display("Watchdog: the tests did not finish within %0d cycles, the scaler hangs", limit);
		$display("*** TEST FAILED ***");
		$fatal(1, "watchdog expired");
	end

	initial begin
		i_rst_n <= 1'b0;
		i_cfg <= '0;
		i_in_valid <= 1'b0;
		i_in_pixel <= '0;
		i_out_ready <= 1'b1;
		repeat (15) @(posedge i_ClkB);
		// neither stream may handshake while reset is held
		@(negedge i_ClkB);
		check_value("input ready during reset", {31'd0, o_in_ready}, 32'd0);
		check_value("output valid during reset", {31'd0, o_out_valid}, 32'd0);
		@(posedge i_ClkB);
		i_rst_n <= 1'b1;
		@(posedge i_ClkB);
		@(negedge i_ClkB);
		check_value("input ready after reset", {31'd0, o_in_ready}, 32'd1);

		test_identity();
		test_upscale();
		test_downscale();
		test_fractional_ratio();
		test_back_to_back();

		// no stray beats once the last frame is out
		repeat (50) begin
			@(negedge i_ClkB);
			check_value("output valid after the last frame", {31'd0, o_out_valid}, 32'd0);
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
